// File: cpu_input.txt
// header at 00: program length, store count, cycles with alu_overflow high
// program words from 10, store records from 80 as address then data
@00
0000002F 0000000F 00000002
@10
50100005 5020000C 58307FF0 // r1 = 5, r2 = 12, r3 = 7ff0
40408800 40520401 40619002 // add r4, sub r5, and r6
40708804 40818403 40908806 // or r7, xor r8, slt r9
14400040 14500041 14600042 // store r4 r5 r6
14700043 14800044 14900045 // store r7 r8 r9
50A48002 14A00046          // addi r10 from r9, store it right behind
04B00040 50C58001 14C00047 // load r11 then use it
04D00005 14D00048          // preset word at 14 straight into a store
40E6B400 40F73800 4107B801 // r14 = 2*r13, then two overflows
14F00049 1500004A          // store r15 r16
4C108003 1410004B 1420004B // beq taken over two stores
4C20C002 1410004B          // bne taken over one store
4C208002 1410004B          // beq not taken
4C22C002 1420004C          // bne not taken
48000002 1410004D          // j over one store
51100005 4C188002 1420004D // beq on r17 from REG2, taken
1510004D                   // store r17
0520004D 4C194002 1520004E // load then bne not taken after the stall
64000000 1410004F          // halt, the store behind it never runs
@80
00000100 00000011
00000104 0000000C
00000108 00000010
0000010C 0000000D
00000110 00007FF5
00000114 00000001
00000118 00000003
0000011C 00000012
00000120 DA7A0014
00000124 69E80050
00000128 B4F40028
0000012C 00000005
00000130 0000000C
00000134 00000005
00000138 00000005

// File: flist.f
+incdir+.
cpu_pkg.sv
alu.sv
regfile.sv
controller.sv
forward.sv
regwalls.sv
pc.sv
cpu.sv
cpu_sva.sv
tb_cpu.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the cpu testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_cpu -f flist.f -o sim_cpu
./obj_dir/sim_cpu | tee sim.log

if grep -q "TB FAILED" sim.log; then
	exit 1
fi

// File: tb_cpu.sv
module tb_cpu;
	import cpu_pkg::*;

	// input file layout: header at 0, program at 'h10, store records at 'h80
	localparam int PROG_BASE  = 'h10;
	localparam int STORE_BASE = 'h80;
	localparam int PROG_MAX   = STORE_BASE - PROG_BASE;

	logic      clock = 1'b0;
	logic      rst = 1'b1;
	imem_req_t imem_req;
	logic      imem_ready = 1'b0;
	word_t     imem_rdata;
	dmem_req_t dmem_req;
	logic      dmem_ready = 1'b0;
	word_t     dmem_rdata;
	logic      alu_overflow;
	logic      halted;

	word_t        vectors [256];
	word_t        imem [256];
	word_t        dmem [256];
	logic [255:0] written = '0;
	integer       seed = 18960;
	int           nprog = 0;
	int           nstores = 0;
	int           ovf_expected = 0;
	int           store_idx = 0;
	int           write_errors = 0;
	int           run_errors = 0;
	int           ovf_cycles = 0;
	int           cycles = 0;
	int           cycle_limit = 0;

	cpu uut (
		.clock(clock),
		.rst(rst),
		.imem_req(imem_req),
		.imem_ready(imem_ready),
		.imem_rdata(imem_rdata),
		.dmem_req(dmem_req),
		.dmem_ready(dmem_ready),
		.dmem_rdata(dmem_rdata),
		.alu_overflow(alu_overflow),
		.halted(halted)
	);

	// untouched data words read back a pattern of their own address
	function automatic word_t fill_word(input word_t addr);
		return 32'hDA7A_0000 ^ addr;
	endfunction

	task automatic check_store(input word_t addr, input word_t data);
		word_t exp_addr;
		word_t exp_data;
		assert (store_idx < nstores) else begin
			write_errors++;
			$display("extra store of %h to address %h after the last expected one",
				data, addr);
		end
		if (store_idx < nstores) begin
			exp_addr = vectors[STORE_BASE + 2 * store_idx];
			exp_data = vectors[STORE_BASE + 2 * store_idx + 1];
			assert (addr == exp_addr) else begin
				write_errors++;
				$display("MISMATCH dmem_req.addr store %0d: got %h expected %h",
					store_idx, addr, exp_addr);
			end
			assert (data == exp_data) else begin
				write_errors++;
				$display("MISMATCH dmem_req.wdata store %0d: got %h expected %h",
					store_idx, data, exp_data);
			end
		end
		store_idx++;
	endtask

	initial begin
		forever #4 clock = ~clock;
	end

	// ready about three cycles in four on each port
	always @(posedge clock) begin
		imem_ready <= ($random(seed) & 3) != 0;
		dmem_ready <= ($random(seed) & 3) != 0;
	end

	// combinational read ports
	assign imem_rdata = imem[imem_req.addr[9:2]];
	assign dmem_rdata = written[dmem_req.addr[9:2]] ? dmem[dmem_req.addr[9:2]] :
		fill_word(dmem_req.addr);

	// a write lands on its ready edge
	always @(posedge clock) begin
		if (!rst && dmem_req.valid && dmem_req.write && dmem_ready) begin
			dmem[dmem_req.addr[9:2]] <= dmem_req.wdata;
			written[dmem_req.addr[9:2]] <= 1'b1;
			check_store(dmem_req.addr, dmem_req.wdata);
		end
	end

	initial begin
		$readmemh("cpu_input.txt", vectors);
		nprog = int'(vectors[0]);
		nstores = int'(vectors[1]);
		ovf_expected = int'(vectors[2]);
		assert (nprog > 0 && nprog <= PROG_MAX) else begin
			run_errors++;
			$display("input file gives no usable program length");
		end
		for (int i = 0; i < 256; i++)
			imem[i] = '0;
		for (int i = 0; i < nprog && i < PROG_MAX; i++)
			imem[i] = vectors[PROG_BASE + i];
		cycle_limit = 40 * nprog;

		repeat (3) @(posedge clock);
		rst <= 1'b0;
		// sampled mid-cycle, ready only moves on the rising edge
		while (!halted && cycles < cycle_limit) begin
			@(negedge clock);
			cycles++;
			if (alu_overflow)
				ovf_cycles++;
		end

		assert (halted) else begin
			run_errors++;
			$display("timeout, halted did not rise within %0d cycles", cycle_limit);
		end
		assert (store_idx >= nstores) else begin
			run_errors++;
			$display("only %0d of %0d expected stores were seen", store_idx, nstores);
		end
		assert (ovf_cycles == ovf_expected) else begin
			run_errors++;
			$display("MISMATCH alu_overflow cycles: got %h expected %h",
				ovf_cycles, ovf_expected);
		end
		$display("errors: %0d in store checks, %0d in end of run checks",
			write_errors, run_errors);
		if (write_errors == 0 && run_errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// File: cpu_sva.sv
module cpu_sva (
	input logic               clock,
	input logic               rst,
	input cpu_pkg::imem_req_t imem_req,
	input logic               imem_ready,
	input cpu_pkg::dmem_req_t dmem_req,
	input logic               dmem_ready,
	input logic               halted
);

	// a waiting request keeps every field
	imem_stable: assert property (@(posedge clock) disable iff (rst)
		imem_req.valid && !imem_ready |=> $stable(imem_req))
		else $error("instruction request changed before ready");

	dmem_stable: assert property (@(posedge clock) disable iff (rst)
		dmem_req.valid && !dmem_ready |=> $stable(dmem_req))
		else $error("data request changed before ready");

	// walls are cleared by the first reset edge
	reset_quiet: assert property (@(posedge clock)
		rst && $past(rst) |-> !imem_req.valid && !dmem_req.valid)
		else $error("memory request valid during reset");

	halted_sticky: assert property (@(posedge clock) disable iff (rst)
		halted |=> halted)
		else $error("halted fell without a reset");

endmodule

bind cpu cpu_sva u_cpu_sva (
	.clock(clock),
	.rst(rst),
	.imem_req(imem_req),
	.imem_ready(imem_ready),
	.dmem_req(dmem_req),
	.dmem_ready(dmem_ready),
	.halted(halted)
);

// File: cpu.sv
module cpu (
	input  logic               clock,
	input  logic               rst,
	output cpu_pkg::imem_req_t imem_req,
	input  logic               imem_ready,
	input  cpu_pkg::word_t     imem_rdata,
	output cpu_pkg::dmem_req_t dmem_req,
	input  logic               dmem_ready,
	input  cpu_pkg::word_t     dmem_rdata,
	output logic               alu_overflow,
	output logic               halted
);
	import cpu_pkg::*;

	logic      advance;
	logic      hazard;
	logic      redirect;
	logic      flush;
	logic      branch_taken;
	logic      jump;
	logic      alu_ovf;
	logic      dmem_done;
	logic      halted_q;
	word_t     fetch_pc;
	word_t     reg1_instr;
	word_t     reg1_pc;
	word_t     imm;
	word_t     target_offset;
	word_t     pc_offset;
	word_t     ra_data, rb_data;
	word_t     ra_fwd, rb_fwd;
	word_t     alu_b;
	word_t     alu_result;
	word_t     dmem_hold;
	word_t     load_data;
	word_t     reg3_data;
	reg_addr_t ra_addr, rb_addr;
	ctrl_t     ctrl;
	id_ex_t    id_in, reg2;
	ex_mem_t   ex_in, reg3;
	mem_wb_t   wb_in, reg4;

	// one stall for the whole core while either port is waiting
	assign advance = !(imem_req.valid && !imem_ready) && !(dmem_req.valid && !dmem_ready);

	// a data access that finished during a fetch stall is not issued again
	always_ff @(posedge clock) begin
		if (rst || advance)
			dmem_done <= 1'b0;
		else if (dmem_req.valid && dmem_ready)
			dmem_done <= 1'b1;
	end

	always_ff @(posedge clock) begin
		if (dmem_req.valid && dmem_ready)
			dmem_hold <= dmem_rdata;
	end

	assign dmem_req = '{valid: (reg3.ctrl.mem_read || reg3.ctrl.mem_write) && !dmem_done,
		write: reg3.ctrl.mem_write, addr: reg3.result, wdata: reg3.store};
	assign load_data = dmem_done ? dmem_hold : dmem_rdata;
	assign reg3_data = reg3.ctrl.mem_read ? load_data : reg3.result;

	// branches wait for their operands like any other consumer
	assign redirect = (branch_taken || jump) && !hazard;
	assign flush    = redirect || ctrl.is_halt || !imem_req.valid;
	// target is relative to the decoding word, pc counts from the fetch address
	assign pc_offset = target_offset - (fetch_pc - reg1_pc);

	assign id_in = '{ctrl: ctrl, opa: ra_fwd, opb: rb_fwd, imm: imm, store: rb_fwd};
	assign alu_b = reg2.ctrl.use_imm ? reg2.imm : reg2.opb;
	assign ex_in = '{ctrl: reg2.ctrl, result: alu_result, store: reg2.store,
		ovf: alu_ovf && reg2.ctrl.check_ovf};
	assign wb_in = '{reg_write: reg3.ctrl.reg_write, dest: reg3.ctrl.dest,
		data: reg3_data, is_halt: reg3.ctrl.is_halt};

	assign alu_overflow = reg3.ovf && advance;

	always_ff @(posedge clock) begin
		if (rst)
			halted_q <= 1'b0;
		else if (advance && reg4.is_halt)
			halted_q <= 1'b1;
	end

	assign halted = halted_q || reg4.is_halt;

	pc u_pc (
		.clock(clock),
		.rst(rst),
		.advance(advance),
		.hazard(hazard),
		.redirect(redirect),
		.target_offset(pc_offset),
		.halt_seen(ctrl.is_halt),
		.imem_req(imem_req),
		.fetch_pc(fetch_pc)
	);

	regwalls u_regwalls (
		.clock(clock),
		.rst(rst),
		.advance(advance),
		.hazard(hazard),
		.flush(flush),
		.fetch_word(imem_rdata),
		.fetch_pc(fetch_pc),
		.reg1_instr(reg1_instr),
		.reg1_pc(reg1_pc),
		.id_in(id_in),
		.reg2(reg2),
		.ex_in(ex_in),
		.reg3(reg3),
		.wb_in(wb_in),
		.reg4(reg4)
	);

	controller u_controller (
		.instr(reg1_instr),
		.ra_fwd(ra_fwd),
		.rb_fwd(rb_fwd),
		.ctrl(ctrl),
		.imm(imm),
		.ra_addr(ra_addr),
		.rb_addr(rb_addr),
		.branch_taken(branch_taken),
		.jump(jump),
		.target_offset(target_offset)
	);

	regfile u_regfile (
		.clock(clock),
		.rst(rst),
		.advance(advance),
		.ra_addr(ra_addr),
		.rb_addr(rb_addr),
		.ra_data(ra_data),
		.rb_data(rb_data),
		.wb(reg4)
	);

	forward u_forward (
		.ra_addr(ra_addr),
		.rb_addr(rb_addr),
		.ra_data(ra_data),
		.rb_data(rb_data),
		.reg2(reg2),
		.reg2_result(alu_result),
		.reg3_data(reg3_data),
		.reg3(reg3),
		.reg4(reg4),
		.ra_fwd(ra_fwd),
		.rb_fwd(rb_fwd),
		.hazard(hazard)
	);

	alu u_alu (
		.op(reg2.ctrl.alu_op),
		.a(reg2.opa),
		.b(alu_b),
		.result(alu_result),
		.overflow(alu_ovf)
	);

endmodule

// File: pc.sv
`include "cpu_cfg.svh"

module pc (
	input  logic               clock,
	input  logic               rst,
	input  logic               advance,
	input  logic               hazard,
	input  logic               redirect,
	input  cpu_pkg::word_t     target_offset,
	input  logic               halt_seen,
	output cpu_pkg::imem_req_t imem_req,
	output cpu_pkg::word_t     fetch_pc
);
	import cpu_pkg::*;

	fetch_state_t state;
	word_t        pc_q;

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= FETCH_RUN;
			pc_q  <= `CPU_RESET_PC;
		end else if (advance && state == FETCH_RUN) begin
			if (halt_seen)
				state <= FETCH_HALT;
			if (redirect)
				pc_q <= pc_q + target_offset;
			else if (!hazard)
				pc_q <= pc_q + 4;
		end
	end

	// no fetch during reset or once a halt has been decoded
	assign imem_req.valid = (state == FETCH_RUN) && !rst;
	assign imem_req.addr  = pc_q;
	assign fetch_pc       = pc_q;

endmodule

// File: regwalls.sv
module regwalls (
	input  logic             clock,
	input  logic             rst,
	input  logic             advance,
	input  logic             hazard,
	input  logic             flush,
	input  cpu_pkg::word_t   fetch_word,
	input  cpu_pkg::word_t   fetch_pc,
	output cpu_pkg::word_t   reg1_instr,
	output cpu_pkg::word_t   reg1_pc,
	input  cpu_pkg::id_ex_t  id_in,
	output cpu_pkg::id_ex_t  reg2,
	input  cpu_pkg::ex_mem_t ex_in,
	output cpu_pkg::ex_mem_t reg3,
	input  cpu_pkg::mem_wb_t wb_in,
	output cpu_pkg::mem_wb_t reg4
);
	import cpu_pkg::*;

	// opcode 0 is unassigned, so an all-zero word decodes as a no-op
	localparam word_t NOP_WORD = '0;

	// REG1, held while a load-use stall is resolved
	always_ff @(posedge clock) begin
		if (advance && !hazard) begin
			reg1_pc    <= fetch_pc;
			reg1_instr <= flush ? NOP_WORD : fetch_word;
		end
		if (rst)
			reg1_instr <= NOP_WORD;
	end

	// REG2
	always_ff @(posedge clock) begin
		if (advance) begin
			reg2 <= id_in;
			// bubble behind the stalled decode
			if (hazard)
				reg2.ctrl <= '0;
		end
		if (rst)
			reg2.ctrl <= '0;
	end

	// REG3
	always_ff @(posedge clock) begin
		if (advance)
			reg3 <= ex_in;
		if (rst) begin
			reg3.ctrl <= '0;
			reg3.ovf  <= 1'b0;
		end
	end

	// REG4
	always_ff @(posedge clock) begin
		if (advance)
			reg4 <= wb_in;
		if (rst) begin
			reg4.reg_write <= 1'b0;
			reg4.is_halt   <= 1'b0;
		end
	end

endmodule

// File: forward.sv
module forward (
	input  cpu_pkg::reg_addr_t ra_addr,
	input  cpu_pkg::reg_addr_t rb_addr,
	input  cpu_pkg::word_t     ra_data,
	input  cpu_pkg::word_t     rb_data,
	input  cpu_pkg::id_ex_t    reg2,
	input  cpu_pkg::word_t     reg2_result,
	input  cpu_pkg::word_t     reg3_data,
	input  cpu_pkg::ex_mem_t   reg3,
	input  cpu_pkg::mem_wb_t   reg4,
	output cpu_pkg::word_t     ra_fwd,
	output cpu_pkg::word_t     rb_fwd,
	output logic               hazard
);
	import cpu_pkg::*;

	// youngest producer wins, r0 is never forwarded
	function automatic word_t pick(input reg_addr_t addr, input word_t rf_data);
		word_t val;
		val = rf_data;
		if (addr != '0) begin
			if (reg2.ctrl.reg_write && reg2.ctrl.dest == addr)
				val = reg2_result;
			else if (reg3.ctrl.reg_write && reg3.ctrl.dest == addr)
				val = reg3_data;
			else if (reg4.reg_write && reg4.dest == addr)
				val = reg4.data;
		end
		return val;
	endfunction

	always_comb begin
		ra_fwd = pick(ra_addr, ra_data);
		rb_fwd = pick(rb_addr, rb_data);
	end

	// load data only exists one stage later
	always_comb begin
		hazard = 1'b0;
		if (reg2.ctrl.mem_read && reg2.ctrl.dest != '0) begin
			if (reg2.ctrl.dest == ra_addr || reg2.ctrl.dest == rb_addr)
				hazard = 1'b1;
		end
	end

endmodule

// File: controller.sv
module controller (
	input  cpu_pkg::word_t     instr,
	input  cpu_pkg::word_t     ra_fwd,
	input  cpu_pkg::word_t     rb_fwd,
	output cpu_pkg::ctrl_t     ctrl,
	output cpu_pkg::word_t     imm,
	output cpu_pkg::reg_addr_t ra_addr,
	output cpu_pkg::reg_addr_t rb_addr,
	output logic               branch_taken,
	output logic               jump,
	output cpu_pkg::word_t     target_offset
);
	import cpu_pkg::*;

	opcode_t opcode;
	logic    use_ra;
	logic    use_rb;
	logic    rb_is_rt;
	logic    is_branch;

	assign opcode = opcode_t'(instr[30:25]);

	// source selection, kept apart from the branch compare
	always_comb begin
		use_ra   = 1'b0;
		use_rb   = 1'b0;
		rb_is_rt = 1'b0;
		case (opcode)
			OP_ALU: begin
				use_ra = 1'b1;
				use_rb = 1'b1;
			end
			OP_ADDI, OP_ORI, OP_LWI: use_ra = 1'b1;
			// store data and branch compare come from rt
			OP_SWI, OP_BR1: begin
				use_ra   = 1'b1;
				use_rb   = 1'b1;
				rb_is_rt = 1'b1;
			end
			default: use_ra = 1'b0;
		endcase
	end

	// unused sources read r0 so they never match a producer
	assign ra_addr = use_ra ? instr[19:15] : '0;
	assign rb_addr = !use_rb ? '0 : (rb_is_rt ? instr[24:20] : instr[14:10]);

	always_comb begin
		ctrl          = '0;
		imm           = '0;
		is_branch     = 1'b0;
		jump          = 1'b0;
		target_offset = '0;
		ctrl.dest     = instr[24:20];
		case (opcode)
			OP_ALU: begin
				ctrl.reg_write = 1'b1;
				case (instr[4:0])
					5'h00: begin
						ctrl.alu_op    = ALU_ADD;
						ctrl.check_ovf = 1'b1;
					end
					5'h01: begin
						ctrl.alu_op    = ALU_SUB;
						ctrl.check_ovf = 1'b1;
					end
					5'h02: ctrl.alu_op = ALU_AND;
					5'h03: ctrl.alu_op = ALU_XOR;
					5'h04: ctrl.alu_op = ALU_OR;
					5'h06: ctrl.alu_op = ALU_SLT;
					default: ctrl.reg_write = 1'b0;
				endcase
			end
			OP_ADDI: begin
				ctrl.use_imm   = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.check_ovf = 1'b1;
				imm            = word_t'($signed(instr[14:0]));
			end
			OP_ORI: begin
				ctrl.alu_op    = ALU_OR;
				ctrl.use_imm   = 1'b1;
				ctrl.reg_write = 1'b1;
				imm            = word_t'(instr[14:0]);
			end
			// word-scaled displacement
			OP_LWI: begin
				ctrl.use_imm   = 1'b1;
				ctrl.mem_read  = 1'b1;
				ctrl.reg_write = 1'b1;
				imm            = word_t'($signed(instr[14:0])) << 2;
			end
			OP_SWI: begin
				ctrl.use_imm   = 1'b1;
				ctrl.mem_write = 1'b1;
				imm            = word_t'($signed(instr[14:0])) << 2;
			end
			OP_BR1: begin
				is_branch     = 1'b1;
				target_offset = word_t'($signed(instr[13:0])) << 2;
			end
			OP_J: begin
				jump          = 1'b1;
				target_offset = word_t'($signed(instr[23:0])) << 2;
			end
			OP_HALT: ctrl.is_halt = 1'b1;
			default: ctrl = '0;
		endcase
	end

	assign branch_taken = is_branch && (instr[14] ? (ra_fwd != rb_fwd) : (ra_fwd == rb_fwd));

endmodule

// File: regfile.sv
`include "cpu_cfg.svh"

module regfile (
	input  logic               clock,
	input  logic               rst,
	input  logic               advance,
	input  cpu_pkg::reg_addr_t ra_addr,
	input  cpu_pkg::reg_addr_t rb_addr,
	output cpu_pkg::word_t     ra_data,
	output cpu_pkg::word_t     rb_data,
	input  cpu_pkg::mem_wb_t   wb
);
	import cpu_pkg::*;

	word_t regs [`CPU_NREGS];

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < `CPU_NREGS; i++)
				regs[i] <= '0;
		end else if (advance && wb.reg_write && wb.dest != '0) begin
			regs[wb.dest] <= wb.data;
		end
	end

	// write-through so decode sees this cycle's write-back
	assign ra_data = (wb.reg_write && wb.dest == ra_addr && ra_addr != '0) ?
		wb.data : regs[ra_addr];
	assign rb_data = (wb.reg_write && wb.dest == rb_addr && rb_addr != '0) ?
		wb.data : regs[rb_addr];

endmodule

// File: alu.sv
module alu (
	input  cpu_pkg::alu_op_t op,
	input  cpu_pkg::word_t   a,
	input  cpu_pkg::word_t   b,
	output cpu_pkg::word_t   result,
	output logic             overflow
);
	import cpu_pkg::*;

	localparam int MSB = $bits(word_t) - 1;

	word_t sum;
	word_t diff;

	assign sum  = a + b;
	assign diff = a - b;

	always_comb begin
		result   = '0;
		overflow = 1'b0;
		case (op)
			ALU_ADD: begin
				result = sum;
				// operands agree in sign, result does not
				overflow = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);
			end
			ALU_SUB: begin
				result   = diff;
				overflow = (a[MSB] != b[MSB]) && (diff[MSB] != a[MSB]);
			end
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_XOR: result = a ^ b;
			// signed compare
			ALU_SLT: result = word_t'($signed(a) < $signed(b));
			default: result = '0;
		endcase
	end

endmodule

// File: cpu_pkg.sv
`include "cpu_cfg.svh"

package cpu_pkg;

	typedef logic [`CPU_XLEN-1:0] word_t;
	typedef logic [$clog2(`CPU_NREGS)-1:0] reg_addr_t;

	// primary opcode, instr[30:25]
	typedef enum logic [5:0] {
		OP_LWI  = 6'h02,
		OP_SWI  = 6'h0a,
		OP_ALU  = 6'h20,
		// instr[23:0] is the word offset
		OP_J    = 6'h24,
		// beq when instr[14] is clear, bne when set
		OP_BR1  = 6'h26,
		OP_ADDI = 6'h28,
		OP_ORI  = 6'h2c,
		OP_HALT = 6'h32
	} opcode_t;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SLT = 3'd5
	} alu_op_t;

	typedef enum logic {
		FETCH_RUN,
		FETCH_HALT
	} fetch_state_t;

	typedef struct packed {
		logic  valid;
		word_t addr;
	} imem_req_t;

	typedef struct packed {
		logic  valid;
		logic  write;
		word_t addr;
		word_t wdata;
	} dmem_req_t;

	typedef struct packed {
		alu_op_t   alu_op;
		logic      use_imm;
		logic      mem_read;
		logic      mem_write;
		logic      reg_write;
		// add and sub that report signed overflow
		logic      check_ovf;
		logic      is_halt;
		reg_addr_t dest;
	} ctrl_t;

	// REG2
	typedef struct packed {
		ctrl_t ctrl;
		word_t opa;
		word_t opb;
		word_t imm;
		word_t store;
	} id_ex_t;

	// REG3
	typedef struct packed {
		ctrl_t ctrl;
		word_t result;
		word_t store;
		logic  ovf;
	} ex_mem_t;

	// REG4
	typedef struct packed {
		logic      reg_write;
		reg_addr_t dest;
		word_t     data;
		logic      is_halt;
	} mem_wb_t;

endpackage

// File: cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// data and address width
`define CPU_XLEN 32

// architectural registers, r0 hardwired to zero
`define CPU_NREGS 32

// first fetch address after reset
`define CPU_RESET_PC 32'h0000_0000

`endif
